// File: build.f
rtl/ooo_pkg.sv
rtl/free_list.sv
rtl/rename_stage.sv
rtl/reorder_buffer.sv
rtl/retire_stage.sv
rtl/ooo_core.sv
test/tb_ooo_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ooo_core
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Done: no errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/tb_ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core;

  localparam int num_rob    = 8;
  localparam int idx_w      = $clog2(num_rob);
  localparam int fl_depth   = ooo_pkg::num_phys_regs - ooo_pkg::num_arch_regs;
  localparam int max_cycles = 2000;  // Sequences need roughly 600

  typedef struct packed {
    ooo_pkg::rob_entry_t entry;
    logic [idx_w-1:0]    rob_idx;
    logic                done;
  } inflight_t;

  logic                   clock;
  logic                   reset;
  logic                   inst_valid;
  ooo_pkg::dispatch_t     inst;
  logic                   inst_ready;
  logic                   complete_valid;
  logic [idx_w-1:0]       complete_rob_idx;
  logic                   commit_valid;
  ooo_pkg::commit_t       commit;
  logic [31:0]            completed_insts;
  ooo_pkg::error_status_e error_status;

  // Reference model state
  inflight_t              rob_q [$];
  ooo_pkg::phys_idx_t     fl_q [$];
  ooo_pkg::phys_idx_t     map_m [ooo_pkg::num_arch_regs];
  logic [idx_w-1:0]       next_idx;
  logic                   ready_m;
  logic                   cvalid_m;
  ooo_pkg::commit_t       commit_m;
  logic [31:0]            count_m;
  ooo_pkg::error_status_e status_m;
  logic                   halted_m;
  logic                   accepted_now;

  // Model outputs as seen by the checks, one cycle behind the edge
  logic                   exp_ready;
  logic                   exp_commit_valid;
  ooo_pkg::commit_t       exp_commit;
  logic [31:0]            exp_count;
  ooo_pkg::error_status_e exp_status;

  ooo_pkg::dispatch_t     send_q [$];
  integer                 seed = 32'h03aa5af3;
  logic [63:0]            npc_next;
  int                     idle_pct;
  int                     cmp_pct;
  int                     cycle_count;
  int                     commits_seen;
  int                     expected_commits;

  ooo_core #(
    .num_rob (num_rob)
  ) uut (
    .clock            (clock),
    .reset            (reset),
    .inst_valid       (inst_valid),
    .inst             (inst),
    .inst_ready       (inst_ready),
    .complete_valid   (complete_valid),
    .complete_rob_idx (complete_rob_idx),
    .commit_valid     (commit_valid),
    .commit           (commit),
    .completed_insts  (completed_insts),
    .error_status     (error_status)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  task automatic stop_on_mismatch(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    $display("Done: errors found");
    $fatal(1, "stopped at the first failed check");
  endtask

  function automatic int rand_below(input int n);
    rand_below = $unsigned($random(seed)) % n;
  endfunction

  task automatic reset_model();
    rob_q.delete();
    fl_q.delete();
    for (int i = 0; i < fl_depth; i++) begin
      fl_q.push_back(ooo_pkg::phys_idx_t'(ooo_pkg::num_arch_regs + i));
    end
    for (int i = 0; i < ooo_pkg::num_arch_regs; i++) begin
      map_m[i] = ooo_pkg::phys_idx_t'(i);
    end
    next_idx     = '0;
    ready_m      = 1'b1;
    cvalid_m     = 1'b0;
    count_m      = '0;
    status_m     = ooo_pkg::no_error;
    halted_m     = 1'b0;
    accepted_now = 1'b0;
  endtask

  // One clock edge of the reference, all decisions from pre-edge state
  task automatic step_model();
    logic      retire_now;
    inflight_t head;
    inflight_t fresh;
    retire_now   = (rob_q.size() > 0) && rob_q[0].done && !halted_m;
    accepted_now = inst_valid && ready_m;
    if (complete_valid) begin
      foreach (rob_q[i]) begin
        if (rob_q[i].rob_idx == complete_rob_idx) rob_q[i].done = 1'b1;
      end
    end
    cvalid_m = retire_now;
    if (retire_now) begin
      head = rob_q.pop_front();
      commit_m.arch_idx = head.entry.inst.arch_dest;
      commit_m.new_phys = head.entry.new_phys;
      commit_m.old_phys = head.entry.old_phys;
      commit_m.wr_en    = head.entry.has_dest;
      commit_m.npc      = head.entry.inst.npc;
      count_m           = count_m + 32'd1;
      if (head.entry.has_dest) fl_q.push_back(head.entry.old_phys);
      if (head.entry.inst.opcode == ooo_pkg::op_halt) status_m = ooo_pkg::halted_on_halt;
      if (head.entry.inst.opcode == ooo_pkg::op_illegal) status_m = ooo_pkg::halted_on_illegal;
      halted_m = (status_m != ooo_pkg::no_error);
    end
    if (accepted_now) begin
      fresh.entry.inst     = inst;
      fresh.entry.has_dest = (inst.arch_dest != 5'd31);
      fresh.entry.old_phys = map_m[inst.arch_dest];
      fresh.entry.new_phys = fresh.entry.old_phys;  // Zero register keeps its tag
      if (fresh.entry.has_dest) begin
        fresh.entry.new_phys  = fl_q.pop_front();
        map_m[inst.arch_dest] = fresh.entry.new_phys;
      end
      fresh.rob_idx = next_idx;
      fresh.done    = 1'b0;
      rob_q.push_back(fresh);
      next_idx = next_idx + 1'b1;
    end
    ready_m = (rob_q.size() < num_rob) && (fl_q.size() > 0) && !halted_m;
  endtask

  always @(posedge clock) begin
    if (commit_valid) commits_seen = commits_seen + 1;
    if (reset) begin
      reset_model();
    end else begin
      step_model();
    end
    exp_ready        <= ready_m;
    exp_commit_valid <= cvalid_m;
    exp_commit       <= commit_m;
    exp_count        <= count_m;
    exp_status       <= status_m;
  end

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout: the sequences did not finish within %0d cycles", max_cycles);
      $display("Done: errors found");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  a_after_reset : assert property (@(posedge clock) disable iff (reset)
    $fell(reset) |-> !commit_valid && inst_ready && completed_insts == '0 &&
      error_status == ooo_pkg::no_error)
    else stop_on_mismatch("outputs after reset are not in their reset state");

  a_ready : assert property (@(posedge clock) disable iff (reset) inst_ready == exp_ready)
    else stop_on_mismatch($sformatf("inst_ready %0b expected %0b",
      $sampled(inst_ready), $sampled(exp_ready)));

  a_commit_valid : assert property (@(posedge clock) disable iff (reset)
    commit_valid == exp_commit_valid)
    else stop_on_mismatch($sformatf("commit_valid %0b expected %0b",
      $sampled(commit_valid), $sampled(exp_commit_valid)));

  a_commit : assert property (@(posedge clock) disable iff (reset)
    commit_valid |-> commit == exp_commit)
    else stop_on_mismatch($sformatf("commit %h expected %h",
      $sampled(commit), $sampled(exp_commit)));

  a_count : assert property (@(posedge clock) disable iff (reset) completed_insts == exp_count)
    else stop_on_mismatch($sformatf("completed_insts %0d expected %0d",
      $sampled(completed_insts), $sampled(exp_count)));

  a_status : assert property (@(posedge clock) disable iff (reset) error_status == exp_status)
    else stop_on_mismatch($sformatf("error_status %0d expected %0d",
      $sampled(error_status), $sampled(exp_status)));

  // About one write in six goes to the zero register
  task automatic queue_inst(input ooo_pkg::opcode_e op);
    ooo_pkg::dispatch_t d;
    d.opcode    = op;
    d.arch_dest = (rand_below(6) == 0) ? 5'd31 : 5'(rand_below(31));
    d.npc       = npc_next;
    npc_next    = npc_next + 64'd4;
    send_q.push_back(d);
  endtask

  task automatic drive_dispatch();
    if (inst_valid && accepted_now) begin
      inst_valid = 1'b0;
      send_q.delete(0);
    end
    if (!inst_valid && send_q.size() > 0 && rand_below(100) >= idle_pct) begin
      inst       = send_q[0];
      inst_valid = 1'b1;
    end
  endtask

  task automatic drive_completion();
    int pick [$];
    complete_valid = 1'b0;
    foreach (rob_q[i]) begin
      if (!rob_q[i].done) pick.push_back(i);
    end
    if (pick.size() > 0 && rand_below(100) < cmp_pct) begin
      complete_rob_idx = rob_q[pick[rand_below(pick.size())]].rob_idx;
      complete_valid   = 1'b1;
    end
  endtask

  task automatic run_cycles(input int n);
    repeat (n) begin
      @(posedge clock);
      #1;
      drive_dispatch();
      drive_completion();
    end
  endtask

  task automatic apply_reset();
    reset          = 1'b1;
    inst_valid     = 1'b0;
    complete_valid = 1'b0;
    send_q.delete();
    repeat (2) @(posedge clock);
    #1 reset = 1'b0;
  endtask

  initial begin
    inst_valid       = 1'b0;
    inst             = '0;
    complete_valid   = 1'b0;
    complete_rob_idx = '0;
    npc_next         = 64'h1000;
    cycle_count      = 0;
    commits_seen     = 0;
    expected_commits = 0;
    apply_reset();

    // Random traffic with out of order completion
    idle_pct = 25;
    cmp_pct  = 45;
    repeat (60) queue_inst(ooo_pkg::op_alu);
    expected_commits += 60;
    while (send_q.size() > 0 || rob_q.size() > 0) run_cycles(1);

    // No completions, so the ROB fills and the ninth instruction waits
    idle_pct = 0;
    cmp_pct  = 0;
    repeat (12) queue_inst(ooo_pkg::op_alu);
    expected_commits += 12;
    run_cycles(20);
    cmp_pct = 40;
    while (send_q.size() > 0 || rob_q.size() > 0) run_cycles(1);

    // Halt in the middle of a stream
    idle_pct = 10;
    cmp_pct  = 50;
    repeat (4) queue_inst(ooo_pkg::op_alu);
    queue_inst(ooo_pkg::op_halt);
    repeat (3) queue_inst(ooo_pkg::op_alu);
    expected_commits += 5;
    while (!halted_m) run_cycles(1);
    run_cycles(20);

    apply_reset();
    idle_pct = 0;
    cmp_pct  = 60;
    repeat (3) queue_inst(ooo_pkg::op_alu);
    queue_inst(ooo_pkg::op_illegal);
    expected_commits += 4;
    while (!halted_m) run_cycles(1);
    run_cycles(10);

    if (commits_seen == expected_commits &&
        error_status == ooo_pkg::halted_on_illegal) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("mismatch at %0t: %0d commits where %0d were expected, error_status %0d",
        $time, commits_seen, expected_commits, error_status);
      $display("Done: errors found");
      $fatal(1, "sequences did not reach their expected end state");
    end
  end

endmodule

`default_nettype wire

// File: rtl/ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core #(
  parameter int num_rob = 8
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       inst_valid,
  input  ooo_pkg::dispatch_t         inst,
  output logic                       inst_ready,
  input  logic                       complete_valid,
  input  logic [$clog2(num_rob)-1:0] complete_rob_idx,
  output logic                       commit_valid,
  output ooo_pkg::commit_t           commit,
  output logic [31:0]                completed_insts,
  output ooo_pkg::error_status_e     error_status
);

  logic                fl_pop;
  logic                fl_not_empty;
  ooo_pkg::phys_idx_t  fl_head_tag;
  logic                free_valid;
  ooo_pkg::phys_idx_t  free_tag;
  logic                rob_write;
  ooo_pkg::rob_entry_t rob_entry;
  logic                rob_not_full;
  logic                head_valid;
  ooo_pkg::rob_entry_t head_entry;
  logic                retire;
  logic                halted;

  free_list fl_0 (
    .clock      (clock),
    .reset      (reset),
    .pop        (fl_pop),
    .head_tag   (fl_head_tag),
    .not_empty  (fl_not_empty),
    .free_valid (free_valid),
    .free_tag   (free_tag)
  );

  rename_stage rename_0 (
    .clock        (clock),
    .reset        (reset),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .inst_ready   (inst_ready),
    .rob_not_full (rob_not_full),
    .fl_not_empty (fl_not_empty),
    .fl_head_tag  (fl_head_tag),
    .fl_pop       (fl_pop),
    .halted       (halted),
    .rob_write    (rob_write),
    .rob_entry    (rob_entry)
  );

  reorder_buffer #(
    .num_rob (num_rob)
  ) rob_0 (
    .clock            (clock),
    .reset            (reset),
    .rob_write        (rob_write),
    .rob_entry        (rob_entry),
    .not_full         (rob_not_full),
    .complete_valid   (complete_valid),
    .complete_rob_idx (complete_rob_idx),
    .head_valid       (head_valid),
    .head_entry       (head_entry),
    .retire           (retire)
  );

  retire_stage retire_0 (
    .clock           (clock),
    .reset           (reset),
    .head_valid      (head_valid),
    .head_entry      (head_entry),
    .retire          (retire),
    .free_valid      (free_valid),
    .free_tag        (free_tag),
    .commit_valid    (commit_valid),
    .commit          (commit),
    .completed_insts (completed_insts),
    .halted          (halted),
    .error_status    (error_status)
  );

endmodule

`default_nettype wire

// File: rtl/retire_stage.sv
`timescale 1ns/1ps
`default_nettype none

module retire_stage (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   head_valid,
  input  ooo_pkg::rob_entry_t    head_entry,
  output logic                   retire,
  output logic                   free_valid,
  output ooo_pkg::phys_idx_t     free_tag,
  output logic                   commit_valid,
  output ooo_pkg::commit_t       commit,
  output logic [31:0]            completed_insts,
  output logic                   halted,
  output ooo_pkg::error_status_e error_status
);

  ooo_pkg::phys_idx_t arch_map [ooo_pkg::num_arch_regs];

  assign halted = (error_status != ooo_pkg::no_error);
  assign retire = head_valid && !halted;  // One per cycle at most

  // Old tag is dead once its overwriter retires
  assign free_valid = retire && head_entry.has_dest;
  assign free_tag   = head_entry.old_phys;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < ooo_pkg::num_arch_regs; i++) begin
        arch_map[i] <= ooo_pkg::phys_idx_t'(i);
      end
      commit_valid    <= 1'b0;
      completed_insts <= '0;
      error_status    <= ooo_pkg::no_error;
    end else begin
      commit_valid <= retire;
      if (retire) begin
        completed_insts <= completed_insts + 32'd1;
        if (head_entry.has_dest) begin
          arch_map[head_entry.inst.arch_dest] <= head_entry.new_phys;
        end
        case (head_entry.inst.opcode)
          ooo_pkg::op_halt:    error_status <= ooo_pkg::halted_on_halt;
          ooo_pkg::op_illegal: error_status <= ooo_pkg::halted_on_illegal;
          default:             ;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (retire) begin
      commit.arch_idx <= head_entry.inst.arch_dest;
      commit.new_phys <= head_entry.new_phys;
      commit.old_phys <= head_entry.old_phys;
      commit.wr_en    <= head_entry.has_dest;
      commit.npc      <= head_entry.inst.npc;
    end
  end

  // Rename and retire agree on the committed mapping
  a_old_matches_arch : assert property (@(posedge clock) disable iff (reset)
    free_valid |-> head_entry.old_phys == arch_map[head_entry.inst.arch_dest]);

endmodule

`default_nettype wire

// File: rtl/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
  parameter int num_rob = 8
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        rob_write,
  input  ooo_pkg::rob_entry_t         rob_entry,
  output logic                        not_full,
  input  logic                        complete_valid,
  input  logic [$clog2(num_rob)-1:0]  complete_rob_idx,
  output logic                        head_valid,
  output ooo_pkg::rob_entry_t         head_entry,
  input  logic                        retire
);

  localparam int idx_w = $clog2(num_rob);

  ooo_pkg::rob_entry_t entries [num_rob];
  logic [num_rob-1:0]  done;
  logic [idx_w-1:0]    head;
  logic [idx_w-1:0]    tail;
  logic [idx_w:0]      count;
  logic [idx_w:0]      cmp_offset;
  logic                cmp_occupied;

  function automatic logic [idx_w-1:0] next_ptr(input logic [idx_w-1:0] ptr);
    next_ptr = (ptr == idx_w'(num_rob - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign not_full   = (count != (idx_w + 1)'(num_rob));
  assign head_valid = (count != '0) && done[head];
  assign head_entry = entries[head];

  // Distance of the completing entry from the head, modulo depth
  always_comb begin
    if (complete_rob_idx >= head) begin
      cmp_offset = {1'b0, complete_rob_idx} - {1'b0, head};
    end else begin
      cmp_offset = {1'b0, complete_rob_idx} + (idx_w + 1)'(num_rob) - {1'b0, head};
    end
  end
  assign cmp_occupied = (cmp_offset < count);

  // Payload only, occupancy is tracked by the pointers
  always_ff @(posedge clock) begin
    if (rob_write) begin
      entries[tail] <= rob_entry;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      done  <= '0;
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (complete_valid) begin
        done[complete_rob_idx] <= 1'b1;  // Any order
      end
      if (rob_write) begin
        done[tail] <= 1'b0;
        tail       <= next_ptr(tail);
      end
      if (retire) begin
        head <= next_ptr(head);
      end
      case ({rob_write, retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  a_no_write_full : assert property (@(posedge clock) disable iff (reset)
    rob_write |-> not_full);

  // Completion names a live entry that has not completed yet
  a_complete_live : assert property (@(posedge clock) disable iff (reset)
    complete_valid |-> cmp_occupied && !done[complete_rob_idx]);

  a_retire_done : assert property (@(posedge clock) disable iff (reset)
    retire |-> head_valid);

endmodule

`default_nettype wire

// File: rtl/rename_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rename_stage (
  input  logic                clock,
  input  logic                reset,
  input  logic                inst_valid,
  input  ooo_pkg::dispatch_t  inst,
  output logic                inst_ready,
  input  logic                rob_not_full,
  input  logic                fl_not_empty,
  input  ooo_pkg::phys_idx_t  fl_head_tag,
  output logic                fl_pop,
  input  logic                halted,
  output logic                rob_write,
  output ooo_pkg::rob_entry_t rob_entry
);

  ooo_pkg::phys_idx_t map_table [ooo_pkg::num_arch_regs];
  ooo_pkg::phys_idx_t cur_map;
  logic               has_dest;
  logic               transfer;

  assign inst_ready = rob_not_full && fl_not_empty && !halted;
  assign transfer   = inst_valid && inst_ready;

  assign has_dest = (inst.arch_dest != ooo_pkg::arch_idx_t'(ooo_pkg::zero_reg));
  assign cur_map  = map_table[inst.arch_dest];

  // Zero register writes take no tag
  assign fl_pop    = transfer && has_dest;
  assign rob_write = transfer;

  always_comb begin
    rob_entry.inst     = inst;
    rob_entry.old_phys = cur_map;
    rob_entry.new_phys = has_dest ? fl_head_tag : cur_map;
    rob_entry.has_dest = has_dest;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < ooo_pkg::num_arch_regs; i++) begin
        map_table[i] <= ooo_pkg::phys_idx_t'(i);  // Identity map
      end
    end else if (fl_pop) begin
      map_table[inst.arch_dest] <= fl_head_tag;
    end
  end

  // A held instruction must not change while it waits
  a_inst_stable : assert property (@(posedge clock) disable iff (reset)
    inst_valid && !inst_ready ##1 inst_valid |-> $stable(inst));

endmodule

`default_nettype wire

// File: rtl/free_list.sv
`timescale 1ns/1ps
`default_nettype none

module free_list (
  input  logic              clock,
  input  logic              reset,
  input  logic              pop,
  output ooo_pkg::phys_idx_t head_tag,
  output logic              not_empty,
  input  logic              free_valid,
  input  ooo_pkg::phys_idx_t free_tag
);

  localparam int fl_depth = ooo_pkg::num_phys_regs - ooo_pkg::num_arch_regs;
  localparam int ptr_w    = $clog2(fl_depth);
  localparam int cnt_w    = $clog2(fl_depth + 1);

  ooo_pkg::phys_idx_t fifo [fl_depth];
  logic [ptr_w-1:0]   head;
  logic [ptr_w-1:0]   tail;
  logic [cnt_w-1:0]   count;

  assign head_tag  = fifo[head];
  assign not_empty = (count != '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      // Starts full with the tags above the architectural range
      for (int i = 0; i < fl_depth; i++) begin
        fifo[i] <= ooo_pkg::phys_idx_t'(ooo_pkg::num_arch_regs + i);
      end
      head  <= '0;
      tail  <= '0;
      count <= cnt_w'(fl_depth);
    end else begin
      if (pop) begin
        head <= head + 1'b1;
      end
      if (free_valid) begin
        fifo[tail] <= free_tag;
        tail       <= tail + 1'b1;
      end
      case ({pop, free_valid})
        2'b10:   count <= count - 1'b1;
        2'b01:   count <= count + 1'b1;
        default: ;  // Both or neither
      endcase
    end
  end

  // Rename must only pop a tag that is there
  a_no_pop_empty : assert property (@(posedge clock) disable iff (reset)
    pop |-> count != '0);

  // A freed tag always has a slot, since only allocated tags come back
  a_no_push_full : assert property (@(posedge clock) disable iff (reset)
    free_valid |-> count != cnt_w'(fl_depth));

endmodule

`default_nettype wire

// File: rtl/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

  localparam int num_arch_regs = 32;
  localparam int num_phys_regs = 48;
  localparam int zero_reg      = 31;  // Never renamed, never written

  typedef logic [4:0] arch_idx_t;
  typedef logic [5:0] phys_idx_t;

  typedef enum logic [1:0] {
    op_alu,
    op_halt,
    op_illegal
  } opcode_e;

  typedef enum logic [1:0] {
    no_error,
    halted_on_halt,
    halted_on_illegal
  } error_status_e;

  // Decoded instruction from the outside agent
  typedef struct packed {
    opcode_e     opcode;
    arch_idx_t   arch_dest;
    logic [63:0] npc;
  } dispatch_t;

  typedef struct packed {
    dispatch_t inst;
    phys_idx_t new_phys;
    phys_idx_t old_phys;
    logic      has_dest;  // Low for writes to zero_reg
  } rob_entry_t;

  typedef struct packed {
    arch_idx_t   arch_idx;
    phys_idx_t   new_phys;
    phys_idx_t   old_phys;
    logic        wr_en;
    logic [63:0] npc;
  } commit_t;

endpackage

`default_nettype wire
